/* hdl/spi_pkg.sv */
package spi_pkg;

    // transfer word, one byte per req/ack cycle
    localparam int word_width = 8;

    // sclk divider input width
    localparam int div_width = 8;

    // transfer controller states
    typedef enum logic [1:0] {
        st_idle         = 2'b00,    // cs_n high, waiting for req
        st_run          = 2'b01,    // sclk running, counting trailing edges
        st_done         = 2'b10,    // bus released, ack goes up next
        st_wait_release = 2'b11     // ack held until req drops
    } ctrl_state_t;

endpackage

/* hdl/spi_clk_gen.sv */
`timescale 1ns/10ps

module spi_clk_gen
    import spi_pkg::*;
(
    input  logic                 sysclk,
    input  logic                 rst_n,
    input  logic                 go,            // run sclk while high
    input  logic                 cpol,          // idle level of sclk
    input  logic [div_width-1:0] divider,       // half-period minus one, in sysclk cycles
    output logic                 sclk,
    output logic                 lead_edge,     // sclk leaves idle at the next sysclk edge
    output logic                 trail_edge     // sclk returns to idle at the next sysclk edge
);

    logic [div_width-1:0] cnt;          // half-period down-counter
    logic                 sclk_q;       // toggling clock state
    logic                 cnt_zero;
    logic                 toggle;

    assign cnt_zero = (cnt == '0);
    assign toggle   = go && cnt_zero;   // flip sclk_q on this cycle

    // divider of 0 toggles every cycle, so the half-period is divider+1 cycles
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            sclk_q <= 1'b0;
        end else if (!go) begin
            cnt    <= divider;          // hold reload value while stopped
            sclk_q <= cpol;             // park at idle level
        end else if (cnt_zero) begin
            cnt    <= divider;
            sclk_q <= ~sclk_q;
        end else begin
            cnt    <= cnt - 1'b1;
        end
    end

    // strobes line up with the sysclk edge that moves sclk
    assign lead_edge  = toggle && (sclk_q == cpol);
    assign trail_edge = toggle && (sclk_q != cpol);

    // outside a transfer sclk follows cpol directly, so a cpol change
    // between transfers shows up on the pin without a cycle of lag
    assign sclk = go ? sclk_q : cpol;

endmodule

/* hdl/spi_shift_reg.sv */
`timescale 1ns/10ps

module spi_shift_reg
    import spi_pkg::*;
(
    input  logic                  sysclk,
    input  logic                  rst_n,
    input  logic                  load,         // copy tx_data at transfer start
    input  logic                  cpha,         // 0: sample lead, 1: sample trail
    input  logic                  lead_edge,
    input  logic                  trail_edge,
    input  logic                  miso,
    input  logic [word_width-1:0] tx_data,
    output logic                  mosi,
    output logic [word_width-1:0] rx_data
);

    logic [word_width-1:0] sr;      // tx bits leave at the top, rx bits enter at the bottom
    logic                  bit_q;   // cpha 0: sampled miso, cpha 1: outgoing mosi bit

    // cpha 0 samples miso into bit_q on lead and shifts it in on trail.
    // cpha 1 shifts out on lead and drops miso straight into sr[0] on trail.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            sr    <= '0;
            bit_q <= 1'b0;
        end else if (load) begin
            sr    <= tx_data;
            bit_q <= tx_data[word_width-1];     // msb on mosi from load in either mode
        end else if (cpha) begin
            if (lead_edge) begin
                bit_q <= sr[word_width-1];      // next bit onto mosi
                sr    <= {sr[word_width-2:0], 1'b0};
            end else if (trail_edge) begin
                sr[0] <= miso;                  // fills the slot freed on lead
            end
        end else begin
            if (lead_edge) begin
                bit_q <= miso;                  // hold until the shift
            end else if (trail_edge) begin
                sr    <= {sr[word_width-2:0], bit_q};
            end
        end
    end

    assign mosi    = cpha ? bit_q : sr[word_width-1];
    assign rx_data = sr;                        // complete after the 8th trailing edge

endmodule

/* hdl/spi_master_ctrl.sv */
`timescale 1ns/10ps

module spi_master_ctrl
    import spi_pkg::*;
(
    input  logic sysclk,
    input  logic rst_n,
    input  logic req,           // host request, four-phase
    input  logic trail_edge,    // from clock generator
    output logic ack,
    output logic cs_n,
    output logic load,          // one-cycle pulse to the shift register
    output logic go             // runs the clock generator
);

    ctrl_state_t                   state;
    logic [$clog2(word_width)-1:0] bit_cnt;    // trailing edges seen so far

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            ack     <= 1'b0;
            cs_n    <= 1'b1;
            load    <= 1'b0;
            go      <= 1'b0;
            bit_cnt <= '0;
        end else begin
            load <= 1'b0;                       // pulse only
            case (state)
                st_idle: begin
                    if (req) begin
                        load    <= 1'b1;
                        cs_n    <= 1'b0;
                        bit_cnt <= '0;
                        state   <= st_run;
                    end
                end

                st_run: begin
                    go <= 1'b1;                 // one cycle after load
                    if (trail_edge) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (&bit_cnt) begin     // all ones on the last bit
                            go    <= 1'b0;
                            cs_n  <= 1'b1;
                            state <= st_done;
                        end
                    end
                end

                st_done: begin
                    ack   <= 1'b1;              // sclk is back at idle here
                    state <= st_wait_release;
                end

                st_wait_release: begin
                    // no restart while req stays high
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

/* hdl/spi_master.sv */
`timescale 1ns/10ps

module spi_master
    import spi_pkg::*;
(
    input  logic                  sysclk,
    input  logic                  rst_n,
    input  logic                  req,
    input  logic                  cpol,
    input  logic                  cpha,
    input  logic                  miso,
    input  logic [word_width-1:0] tx_data,
    input  logic [div_width-1:0]  divider,
    output logic                  ack,
    output logic                  cs_n,
    output logic                  sclk,
    output logic                  mosi,
    output logic [word_width-1:0] rx_data
);

    logic go;           // controller to clock generator
    logic load;         // controller to shift register
    logic lead_edge;
    logic trail_edge;   // also counted by the controller

    spi_master_ctrl ctrl_i (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .req        (req),
        .trail_edge (trail_edge),
        .ack        (ack),
        .cs_n       (cs_n),
        .load       (load),
        .go         (go)
    );

    spi_clk_gen clk_gen_i (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .go         (go),
        .cpol       (cpol),
        .divider    (divider),
        .sclk       (sclk),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge)
    );

    spi_shift_reg shift_reg_i (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .load       (load),
        .cpha       (cpha),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge),
        .miso       (miso),
        .tx_data    (tx_data),
        .mosi       (mosi),
        .rx_data    (rx_data)
    );

endmodule

/* test/spi_master_checker.sv */
`timescale 1ns/10ps

module spi_master_checker
    import spi_pkg::*;
(
    input logic                  sysclk,
    input logic                  rst_n,
    input logic                  req,
    input logic                  ack,
    input logic                  cs_n,
    input logic                  sclk,
    input logic                  cpol,
    input logic [word_width-1:0] rx_data
);

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(ack) |-> req)
        else $error("ack rose while req was low");

    // deselected bus parks sclk at the idle level
    idle_level: assert property (@(posedge sysclk) disable iff (!rst_n)
        cs_n |-> (sclk == cpol))
        else $error("sclk differs from cpol while cs_n is high");

    no_select_in_ack: assert property (@(posedge sysclk) disable iff (!rst_n)
        $fell(cs_n) |-> !$past(ack))
        else $error("cs_n fell while ack was high");

    // received byte held for the whole ack phase
    rx_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
        (ack && $past(ack)) |-> $stable(rx_data))
        else $error("rx_data changed while ack was high");

endmodule

bind spi_master spi_master_checker checker_i (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),
    .cs_n    (cs_n),
    .sclk    (sclk),
    .cpol    (cpol),
    .rx_data (rx_data)
);

/* test/spi_master_tb.sv */
`timescale 1ns/10ps

module spi_master_tb
    import spi_pkg::*;
();

    localparam int          clk_cycle_ns = 40;
    localparam int          n_xfers      = 59;     // 1 + 4 + 2 + 8 + 4 + 40
    localparam int          cycle_limit  = n_xfers * (16 * 8 + 10) * 2;
    localparam logic [31:0] lcg_seed     = 32'h29b1_9720;

    logic                  sysclk;
    logic                  rst_n;
    logic                  req;
    logic                  cpol;
    logic                  cpha;
    logic                  miso;
    logic [word_width-1:0] tx_data;
    logic [div_width-1:0]  divider;
    logic                  ack;
    logic                  cs_n;
    logic                  sclk;
    logic                  mosi;
    logic [word_width-1:0] rx_data;

    string                 cur_name;           // test now on the bus
    logic                  ack_q;
    logic                  cs_q;
    logic [word_width-1:0] prev_tx;            // byte sent in the last transfer
    logic [word_width-1:0] slv_capture;        // byte the slave saw on mosi
    int                    slv_leads;          // leading sclk edges in the last transfer
    int                    gap_min;            // shortest half-period in sysclk cycles
    int                    gap_max;
    int                    drv_tests = 0;
    int                    drv_errs  = 0;
    int                    cmp_tests = 0;
    int                    cmp_errs  = 0;
    int                    mon_errs  = 0;

    spi_master spi_master_i (
        .sysclk  (sysclk),
        .rst_n   (rst_n),
        .req     (req),
        .cpol    (cpol),
        .cpha    (cpha),
        .miso    (miso),
        .tx_data (tx_data),
        .divider (divider),
        .ack     (ack),
        .cs_n    (cs_n),
        .sclk    (sclk),
        .mosi    (mosi),
        .rx_data (rx_data)
    );

    initial begin
        sysclk = 1'b0;
        forever begin
            #(clk_cycle_ns / 2) sysclk = ~sysclk;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected slave capture in the upper byte and expected rx_data in the lower
    function automatic logic [2*word_width-1:0] ref_xfer(input logic [word_width-1:0] tx,
                                                         input logic [word_width-1:0] last_tx,
                                                         input logic first);
        logic [word_width-1:0] resp;
        resp = first ? 8'h3c : ~last_tx;    // slave answers with the inverse of its last byte
        return {tx, resp};
    endfunction

    // SPI slave in the mode set by the host's cpol and cpha
    initial begin : slave_model
        logic [word_width-1:0] tx_sr;
        logic [word_width-1:0] rx_sr;
        logic [word_width-1:0] resp;
        logic                  lead;
        int                    edges;
        int                    gap;
        time                   t_last;
        miso  <= 1'b0;
        resp   = 8'h3c;
        t_last = 0;
        forever begin
            @(negedge cs_n);
            tx_sr     = resp;
            rx_sr     = '0;
            edges     = 0;
            slv_leads = 0;
            gap_min   = 1000;
            gap_max   = 0;
            if (cpha == 1'b0) begin
                miso <= tx_sr[word_width-1];    // first bit out before any edge
            end
            // sixteen sclk edges per byte and the last one coincides with cs_n rising
            while (edges < 2 * word_width) begin
                @(sclk);
                if (edges > 0) begin
                    gap = int'($time - t_last) / clk_cycle_ns;
                    if (gap < gap_min) gap_min = gap;
                    if (gap > gap_max) gap_max = gap;
                end
                t_last = $time;
                edges++;
                lead = (sclk != cpol);
                if (lead) slv_leads++;
                if (cpha == 1'b0) begin
                    if (lead) begin
                        rx_sr = {rx_sr[word_width-2:0], mosi};
                    end else begin
                        tx_sr = {tx_sr[word_width-2:0], 1'b0};
                        miso <= tx_sr[word_width-1];
                    end
                end else begin
                    if (lead) begin
                        miso <= tx_sr[word_width-1];
                        tx_sr = {tx_sr[word_width-2:0], 1'b0};
                    end else begin
                        rx_sr = {rx_sr[word_width-2:0], mosi};
                    end
                end
            end
            // sclk leaving idle again before deselect is an extra leading edge
            while (cs_n !== 1'b1) begin
                @(sclk or cs_n);
                if (sclk !== cpol) slv_leads++;
            end
            slv_capture = rx_sr;
            resp        = ~rx_sr;
        end
    end

    // compare at every rising ack
    always @(posedge sysclk) begin : compare
        logic [2*word_width-1:0] exp_v;
        logic                    ok;
        ack_q <= ack;
        if (rst_n && ack && !ack_q) begin
            exp_v = ref_xfer(tx_data, prev_tx, cmp_tests == 0);
            ok    = 1'b1;
            if (slv_capture !== exp_v[2*word_width-1:word_width]) begin
                ok = 1'b0;
                cmp_errs++;
                $display("FAIL %s capture expected %h actual %h", cur_name,
                         exp_v[2*word_width-1:word_width], slv_capture);
            end
            if (rx_data !== exp_v[word_width-1:0]) begin
                ok = 1'b0;
                cmp_errs++;
                $display("FAIL %s rx_data expected %h actual %h", cur_name,
                         exp_v[word_width-1:0], rx_data);
            end
            if (slv_leads != word_width) begin
                ok = 1'b0;
                cmp_errs++;
                $display("FAIL %s leading edges expected %0d actual %0d", cur_name,
                         word_width, slv_leads);
            end
            if (gap_min != int'(divider) + 1 || gap_max != int'(divider) + 1) begin
                ok = 1'b0;
                cmp_errs++;
                $display("FAIL %s half-period expected %0d actual %0d..%0d", cur_name,
                         int'(divider) + 1, gap_min, gap_max);
            end
            if (ok) $display("PASS %s", cur_name);
            prev_tx = tx_data;
            cmp_tests++;
        end
    end

    // bus rules seen from outside the DUT
    always @(posedge sysclk) begin
        cs_q <= cs_n;
        if (rst_n) begin
            if (cs_n && sclk !== cpol) begin
                mon_errs++;
                $display("sclk left its idle level %b while cs_n was high", cpol);
            end
            if (ack && !ack_q && !req) begin
                mon_errs++;
                $display("ack rose although no request was pending");
            end
            if (!cs_n && cs_q && ack) begin
                mon_errs++;
                $display("cs_n fell while ack was still high");
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge sysclk);
            cycles++;
        end
        $display("timeout after %0d cycles, %s did not complete", cycles, cur_name);
        $display("TEST FAILED");
        $finish;
    end

    task automatic run_xfer(input string name, input logic [word_width-1:0] data,
                            input logic [div_width-1:0] div, input logic pol,
                            input logic pha, input int hold);
        int   n;
        logic held_ok;
        @(posedge sysclk);
        cur_name = name;
        tx_data <= data;
        divider <= div;
        cpol    <= pol;
        cpha    <= pha;
        req     <= 1'b1;
        @(posedge sysclk);
        while (ack !== 1'b1) @(posedge sysclk);
        held_ok = 1'b1;
        repeat (hold) begin                     // req kept high past ack
            @(posedge sysclk);
            if (cs_n !== 1'b1 || ack !== 1'b1) held_ok = 1'b0;
        end
        req <= 1'b0;
        n = 1;
        @(posedge sysclk);
        while (ack !== 1'b0) begin
            @(posedge sysclk);
            n++;
        end
        // ack drops one cycle after req and reads low on the second sample
        if (!held_ok) begin
            drv_errs++;
            $display("FAIL %s: the master restarted or dropped ack while req was held", name);
        end
        if (n != 2) begin
            drv_errs++;
            $display("FAIL %s ack fall delay expected %0d actual %0d", name, 2, n);
        end
        if (hold > 0) begin
            drv_tests++;
            if (held_ok && n == 2) $display("PASS %s handshake, req held %0d cycles", name, hold);
        end
    endtask

    task automatic check_idle(input string name, input logic pol);
        @(posedge sysclk);
        cpol <= pol;
        @(posedge sysclk);
        drv_tests++;
        if (sclk !== pol) begin
            drv_errs++;
            $display("FAIL %s sclk expected %b actual %b", name, pol, sclk);
        end else if (cs_n !== 1'b1) begin
            drv_errs++;
            $display("FAIL %s cs_n expected 1 actual %b", name, cs_n);
        end else begin
            $display("PASS %s", name);
        end
    endtask

    initial begin : stimulus
        logic [31:0] seed;
        int          i;
        int          total_errs;
        rst_n   <= 1'b0;
        req     <= 1'b0;
        cpol    <= 1'b0;
        cpha    <= 1'b0;
        tx_data <= '0;
        divider <= '0;
        seed     = lcg_seed;
        cur_name = "reset";
        repeat (4) @(posedge sysclk);
        rst_n <= 1'b1;
        repeat (2) @(posedge sysclk);

        run_xfer("mode0_div0", 8'ha5, 8'd0, 1'b0, 1'b0, 0);

        for (i = 0; i < 4; i++) begin                   // all cpol/cpha pairs
            seed = lcg_step(seed);
            run_xfer($sformatf("mode_cpol%0d_cpha%0d", i[1], i[0]), seed[31:24], 8'd1,
                     i[1], i[0], 0);
        end

        check_idle("idle_cpol1", 1'b1);
        seed = lcg_step(seed);
        run_xfer("idle_xfer_cpol1", seed[31:24], 8'd2, 1'b1, 1'b0, 0);
        check_idle("idle_cpol0", 1'b0);
        seed = lcg_step(seed);
        run_xfer("idle_xfer_cpol0", seed[31:24], 8'd2, 1'b0, 1'b1, 0);

        for (i = 0; i < 8; i++) begin
            seed = lcg_step(seed);
            run_xfer($sformatf("div_sweep_%0d", i), seed[31:24], i[div_width-1:0],
                     seed[20], seed[19], 0);
        end

        for (i = 0; i < 4; i++) begin
            seed = lcg_step(seed);
            run_xfer($sformatf("handshake_%0d", i), seed[31:24], seed[23:21],
                     seed[20], seed[19], 1 + int'(seed[18:15]));
        end

        for (i = 0; i < 40; i++) begin
            seed = lcg_step(seed);
            run_xfer($sformatf("random_%0d", i), seed[31:24], seed[23:21],
                     seed[20], seed[19], int'(seed[18:17]));
        end

        repeat (4) @(posedge sysclk);
        if (cmp_tests != n_xfers) begin
            drv_errs++;
            $display("only %0d of %0d transfers reached the compare step", cmp_tests, n_xfers);
        end
        total_errs = drv_errs + cmp_errs + mon_errs;
        $display("%0d tests run, %0d transfers compared, %0d errors",
                 drv_tests + cmp_tests, cmp_tests, total_errs);
        if (total_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/spi_pkg.sv
hdl/spi_clk_gen.sv
hdl/spi_shift_reg.sv
hdl/spi_master_ctrl.sv
hdl/spi_master.sv
test/spi_master_checker.sv
test/spi_master_tb.sv

/* Makefile */
TOP := spi_master_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

obj_dir/V$(TOP): compile.f hdl/*.sv test/*.sv
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o V$(TOP)

# the run passes only when the testbench prints its pass line
sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
